//--- compile.f
rtl/ifu_pkg.sv
rtl/fetch_pc_gen.sv
rtl/l1i_array.sv
rtl/l1i_refill_ctrl.sv
rtl/ifu_top.sv
test/tb_mem_model.sv
test/tb_ifu.sv

//--- rtl/fetch_pc_gen.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_pc_gen (
  input  logic                        clock_i,
  input  logic                        reset_i,

  input  logic                        redirect_i,
  input  logic [ifu_pkg::addr_w-1:0]  redirect_pc_i,

  input  logic                        advance_i,
  input  logic                        lookup_i,

  output logic [ifu_pkg::addr_w-1:0]  pc_o
);

  import ifu_pkg::*;

  logic [addr_w-1:0] pc_q;
  logic [addr_w-1:0] redir_pc_q;
  logic              redir_pend_q;

  // a fresh strobe counts as pending in its own cycle.
  logic              redir_any;
  logic [addr_w-1:0] redir_target;
  logic              take_redir;

  assign redir_any    = redirect_i || redir_pend_q;
  assign redir_target = redirect_i ? redirect_pc_i : redir_pc_q;
  assign take_redir   = lookup_i && redir_any;

  assign pc_o = pc_q;

  // pc only moves in lookup, so it stays put during a refill.
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      pc_q <= reset_pc;
    end else if (take_redir) begin
      pc_q <= redir_target; // wins over advance.
    end else if (advance_i) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      redir_pend_q <= 1'b0;
    end else if (take_redir) begin
      redir_pend_q <= 1'b0;
    end else if (redirect_i) begin
      redir_pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clock_i) begin
    if (redirect_i) begin
      redir_pc_q <= redirect_pc_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

  // address and instruction word width.
  localparam int unsigned addr_w = 32;

  // word select inside a two-word line.
  localparam int unsigned offset_bits = 1;

  // four sets.
  localparam int unsigned set_bits = 2;

  // what is left above set, word offset and byte offset.
  localparam int unsigned tag_w = addr_w - set_bits - offset_bits - 2;

  // first fetch address out of reset.
  localparam logic [addr_w-1:0] reset_pc = 32'h8000_0000;

  // refill controller states.
  typedef enum logic [2:0] {
    st_lookup, // compare and deliver.
    st_req0,   // read request for word 0.
    st_wait0,  // wait for word 0.
    st_req1,   // read request for word 1.
    st_wait1,  // wait for word 1.
    st_fill    // mark line valid, apply held invalidate.
  } l1i_state_e;

endpackage

`default_nettype wire

//--- rtl/ifu_top.sv
`default_nettype none
`timescale 1ns/1ps

module ifu_top (
  input  logic                        clock,
  input  logic                        reset,

  input  logic                        redirect_i,
  input  logic [ifu_pkg::addr_w-1:0]  redirect_pc_i,
  input  logic                        invalidate_i,

  // memory read port.
  output logic [ifu_pkg::addr_w-1:0]  araddr_o,
  output logic                        arvalid_o,
  input  logic                        rvalid_i,
  input  logic [ifu_pkg::addr_w-1:0]  rdata_i,

  // instruction out.
  output logic [ifu_pkg::addr_w-1:0]  inst_o,
  output logic [ifu_pkg::addr_w-1:0]  inst_pc_o,
  output logic                        inst_valid_o
);

  import ifu_pkg::*;

  logic [addr_w-1:0] pc;
  logic              hit;
  logic              fill_we;
  logic              fill_word;
  logic              fill_done;
  logic              clear_valid;
  logic              lookup;

  assign inst_pc_o = pc;

  fetch_pc_gen pc_gen_i (
    .clock_i       (clock),
    .reset_i       (reset),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .advance_i     (inst_valid_o), // step on each delivery.
    .lookup_i      (lookup),
    .pc_o          (pc)
  );

  l1i_array array_i (
    .clock_i       (clock),
    .reset_i       (reset),
    .pc_i          (pc),
    .fill_we_i     (fill_we),
    .fill_word_i   (fill_word),
    .fill_done_i   (fill_done),
    .clear_valid_i (clear_valid),
    .fill_data_i   (rdata_i),
    .hit_o         (hit),
    .inst_o        (inst_o)
  );

  l1i_refill_ctrl ctrl_i (
    .clock_i       (clock),
    .reset_i       (reset),
    .pc_i          (pc),
    .hit_i         (hit),
    .rvalid_i      (rvalid_i),
    .invalidate_i  (invalidate_i),
    .araddr_o      (araddr_o),
    .arvalid_o     (arvalid_o),
    .fill_we_o     (fill_we),
    .fill_word_o   (fill_word),
    .fill_done_o   (fill_done),
    .clear_valid_o (clear_valid),
    .lookup_o      (lookup),
    .inst_valid_o  (inst_valid_o)
  );

endmodule

`default_nettype wire

//--- rtl/l1i_array.sv
`default_nettype none
`timescale 1ns/1ps

module l1i_array (
  input  logic                        clock_i,
  input  logic                        reset_i,

  input  logic [ifu_pkg::addr_w-1:0]  pc_i,

  input  logic                        fill_we_i,
  input  logic                        fill_word_i,
  input  logic                        fill_done_i,
  input  logic                        clear_valid_i,
  input  logic [ifu_pkg::addr_w-1:0]  fill_data_i,

  output logic                        hit_o,
  output logic [ifu_pkg::addr_w-1:0]  inst_o
);

  import ifu_pkg::*;

  // pc fields.
  logic [tag_w-1:0]       pc_tag;
  logic [set_bits-1:0]    pc_set;
  logic [offset_bits-1:0] pc_word;

  // line storage, one tag and one valid bit per line.
  logic [addr_w-1:0]      data_q [2**set_bits][2**offset_bits];
  logic [tag_w-1:0]       tag_q  [2**set_bits];
  logic [2**set_bits-1:0] valid_q;

  assign pc_tag  = pc_i[addr_w-1:set_bits+offset_bits+2];
  assign pc_set  = pc_i[set_bits+offset_bits+1:offset_bits+2];
  assign pc_word = pc_i[offset_bits+1:2];

  assign hit_o  = valid_q[pc_set] && (tag_q[pc_set] == pc_tag);
  assign inst_o = data_q[pc_set][pc_word];

  // refill writes land in the set of the held pc.
  always_ff @(posedge clock_i) begin
    if (fill_we_i) begin
      data_q[pc_set][fill_word_i] <= fill_data_i;
      tag_q[pc_set]               <= pc_tag;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      if (fill_done_i) begin
        valid_q[pc_set] <= 1'b1; // line complete.
      end
      // an invalidate in the same cycle as the fill must still win.
      if (clear_valid_i) begin
        valid_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/l1i_refill_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module l1i_refill_ctrl (
  input  logic                        clock_i,
  input  logic                        reset_i,

  input  logic [ifu_pkg::addr_w-1:0]  pc_i,
  input  logic                        hit_i,
  input  logic                        rvalid_i,
  input  logic                        invalidate_i,

  output logic [ifu_pkg::addr_w-1:0]  araddr_o,
  output logic                        arvalid_o,

  output logic                        fill_we_o,
  output logic                        fill_word_o,
  output logic                        fill_done_o,
  output logic                        clear_valid_o,

  output logic                        lookup_o,
  output logic                        inst_valid_o
);

  import ifu_pkg::*;

  l1i_state_e state_q;
  l1i_state_e state_d;

  logic                   inv_pend_q;
  logic                   in_refill;
  logic [offset_bits-1:0] req_word;

  assign lookup_o  = (state_q == st_lookup);
  assign in_refill = !lookup_o && (state_q != st_fill);

  // deliver straight from the array on a hit.
  assign inst_valid_o = lookup_o && hit_i;

  // one-cycle read strobes, word offset forced per request.
  assign arvalid_o = (state_q == st_req0) || (state_q == st_req1);
  assign req_word  = (state_q == st_req1) ? offset_bits'(1) : '0;
  assign araddr_o  = {pc_i[addr_w-1:offset_bits+2], req_word, 2'b00};

  // response data goes to the array the cycle it arrives.
  assign fill_we_o   = rvalid_i && ((state_q == st_wait0) || (state_q == st_wait1));
  assign fill_word_o = (state_q == st_wait1);
  assign fill_done_o = (state_q == st_fill);

  // lookup clears at once, a refill defers it to the fill cycle.
  assign clear_valid_o = (lookup_o && invalidate_i) ||
                         (fill_done_o && (inv_pend_q || invalidate_i));

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_lookup: begin
        if (!hit_i) begin
          state_d = st_req0;
        end
      end
      st_req0: begin
        state_d = st_wait0;
      end
      st_wait0: begin
        if (rvalid_i) begin
          state_d = st_req1;
        end
      end
      st_req1: begin
        state_d = st_wait1;
      end
      st_wait1: begin
        if (rvalid_i) begin
          state_d = st_fill;
        end
      end
      st_fill: begin
        state_d = st_lookup; // next cycle hits.
      end
      default: begin
        state_d = st_lookup;
      end
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q <= st_lookup;
    end else begin
      state_q <= state_d;
    end
  end

  // held invalidate while the line is being written.
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      inv_pend_q <= 1'b0;
    end else if (fill_done_o) begin
      inv_pend_q <= 1'b0; // applied this cycle.
    end else if (in_refill && invalidate_i) begin
      inv_pend_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the instruction fetch testbench with verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

rm -rf "$build_dir" "$log"
if [ $? -ne 0 ]; then
  echo "could not clean the previous build"
  exit 1
fi

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_ifu \
  --Mdir "$build_dir" \
  -o tb_ifu \
  -f compile.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./"$build_dir"/tb_ifu > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
fi

# the log decides the result.
if grep -q -x -F '>>> PASS' "$log"; then
  echo "test passed"
  exit 0
else
  echo "test failed"
  exit 1
fi

//--- test/tb_ifu.sv
`default_nettype none
`timescale 1ns/1ps

module tb_ifu;

  import ifu_pkg::*;

  localparam logic [31:0] data_key   = 32'h5a3c_96e1;
  localparam logic [31:0] lfsr_seed  = 32'hf1f3_9ff8;
  localparam int unsigned wait_limit = 200; // cycles per wait.

  // four lines on sets 0 to 3.
  localparam logic [addr_w-1:0] loop_start = reset_pc;
  localparam logic [addr_w-1:0] loop_turn  = reset_pc + 32'h18;

  logic              clock;
  logic              reset;
  logic              redirect;
  logic [addr_w-1:0] redirect_pc;
  logic              invalidate;
  logic [addr_w-1:0] araddr;
  logic              arvalid;
  logic              rvalid;
  logic [addr_w-1:0] rdata;
  logic [addr_w-1:0] inst;
  logic [addr_w-1:0] inst_pc;
  logic              inst_valid;
  logic [31:0]       req_count;

  // scoreboard state.
  logic              reset_q = 1'b0;
  logic [addr_w-1:0] exp_pc;
  logic              redir_pend;
  logic [addr_w-1:0] redir_target;
  logic [1:0]        req_phase; // 0 idle, 1 word 0 out, 2 word 0 back, 3 word 1 out.
  logic [addr_w-1:0] line_base;
  logic              quiet_loop;

  ifu_top dut_i (
    .clock         (clock),
    .reset         (reset),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .invalidate_i  (invalidate),
    .araddr_o      (araddr),
    .arvalid_o     (arvalid),
    .rvalid_i      (rvalid),
    .rdata_i       (rdata),
    .inst_o        (inst),
    .inst_pc_o     (inst_pc),
    .inst_valid_o  (inst_valid)
  );

  tb_mem_model #(
    .data_key  (data_key),
    .lfsr_seed (lfsr_seed)
  ) mem_i (
    .clock_i     (clock),
    .reset_i     (reset),
    .araddr_i    (araddr),
    .arvalid_i   (arvalid),
    .rvalid_o    (rvalid),
    .rdata_o     (rdata),
    .req_count_o (req_count)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic show_problem(input string what);
    $display("%0t %s", $time, what);
    abort_run();
  endtask

  always @(posedge clock) begin
    reset_q <= reset;
    if (reset) begin
      exp_pc     <= reset_pc;
      redir_pend <= 1'b0;
      req_phase  <= 2'd0;
    end else begin
      if (inst_valid) begin
        if (redir_pend && (inst_pc == redir_target)) begin
          exp_pc     <= redir_target + 32'd4;
          redir_pend <= 1'b0; // target reached.
        end else begin
          exp_pc <= exp_pc + 32'd4;
        end
      end
      if (redirect) begin
        redir_pend   <= 1'b1;
        redir_target <= redirect_pc;
      end
      if (arvalid) begin
        req_phase <= (req_phase == 2'd0) ? 2'd1 : 2'd3;
        if (req_phase == 2'd0) begin
          line_base <= araddr;
        end
      end
      if (rvalid) begin
        req_phase <= (req_phase == 2'd1) ? 2'd2 : 2'd0;
      end
    end
  end

  inst_data_chk: assert property (@(posedge clock) disable iff (reset)
    inst_valid |-> (inst == (inst_pc ^ data_key)))
    else show_mismatch("inst_o", $sampled(inst), $sampled(inst_pc) ^ data_key);

  inst_order_chk: assert property (@(posedge clock) disable iff (reset)
    inst_valid |-> ((inst_pc == exp_pc) || (redir_pend && (inst_pc == redir_target))))
    else show_mismatch("inst_pc_o", $sampled(inst_pc), $sampled(exp_pc));

  req_order_chk: assert property (@(posedge clock) disable iff (reset)
    arvalid |-> ((req_phase == 2'd0) || (req_phase == 2'd2)))
    else show_problem("read request issued before the previous response");

  // a miss is on the next sequential pc or on the redirect target.
  req_base_chk: assert property (@(posedge clock) disable iff (reset)
    (arvalid && (req_phase == 2'd0)) |->
      ((araddr == (exp_pc & ~32'h7)) ||
       (redir_pend && (araddr == (redir_target & ~32'h7)))))
    else show_mismatch("araddr_o", $sampled(araddr), $sampled(exp_pc) & ~32'h7);

  req_second_chk: assert property (@(posedge clock) disable iff (reset)
    (arvalid && (req_phase == 2'd2)) |-> (araddr == (line_base + 32'd4)))
    else show_mismatch("araddr_o", $sampled(araddr), $sampled(line_base) + 32'd4);

  refill_gap_chk: assert property (@(posedge clock) disable iff (reset)
    inst_valid |-> (req_phase == 2'd0))
    else show_problem("instruction delivered in the middle of a line refill");

  quiet_loop_chk: assert property (@(posedge clock) disable iff (reset)
    quiet_loop |-> !arvalid)
    else show_problem("read request while the loop should run from the cache");

  reset_quiet_chk: assert property (@(posedge clock)
    reset_q |-> (!arvalid && !inst_valid))
    else show_problem("arvalid_o or inst_valid_o high during or right after reset");

  task automatic wait_fetch_of(input logic [addr_w-1:0] pc);
    int unsigned n;
    n = 0;
    do begin
      @(negedge clock);
      n = n + 1;
      if (n > wait_limit) begin
        show_problem($sformatf("timeout waiting for the instruction at %h", pc));
      end
    end while (!(inst_valid && (inst_pc == pc)));
  endtask

  task automatic wait_any_fetch(output logic [addr_w-1:0] pc);
    int unsigned n;
    n = 0;
    do begin
      @(negedge clock);
      n = n + 1;
      if (n > wait_limit) begin
        show_problem("timeout waiting for any instruction");
      end
    end while (!inst_valid);
    pc = inst_pc;
  endtask

  task automatic wait_request();
    int unsigned n;
    n = 0;
    do begin
      @(negedge clock);
      n = n + 1;
      if (n > wait_limit) begin
        show_problem("timeout waiting for a read request");
      end
    end while (!arvalid);
  endtask

  task automatic pulse_redirect(input logic [addr_w-1:0] target);
    @(posedge clock);
    #1;
    redirect    = 1'b1;
    redirect_pc = target;
    @(posedge clock);
    #1;
    redirect = 1'b0;
  endtask

  task automatic pulse_invalidate();
    @(posedge clock);
    #1;
    invalidate = 1'b1;
    @(posedge clock);
    #1;
    invalidate = 1'b0;
  endtask

  // the turn word is followed by one more sequential word, then the start.
  task automatic run_loop_pass();
    wait_fetch_of(loop_turn);
    pulse_redirect(loop_start);
    wait_fetch_of(loop_start);
  endtask

  initial begin : stimulus
    logic [31:0]       snap;
    logic [addr_w-1:0] got_pc;
    redirect    = 1'b0;
    redirect_pc = '0;
    invalidate  = 1'b0;
    quiet_loop  = 1'b0;
    reset       = 1'b1;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    run_loop_pass(); // fills all four sets.
    quiet_loop = 1'b1;
    repeat (2) run_loop_pass();
    quiet_loop = 1'b0;

    // clear on a hit, the rest of the line refills.
    wait_fetch_of(loop_start + 32'h4);
    snap = req_count;
    pulse_invalidate();
    wait_any_fetch(got_pc);
    assert (got_pc == loop_start + 32'hc)
      else show_mismatch("inst_pc_o", got_pc, loop_start + 32'hc);
    assert (req_count == snap + 32'd2)
      else show_mismatch("request count", req_count, snap + 32'd2);

    // clear during a refill, so the same line is read twice.
    wait_fetch_of(loop_start + 32'h1c);
    snap = req_count;
    wait_request();
    pulse_invalidate();
    wait_any_fetch(got_pc);
    assert (got_pc == loop_start + 32'h20)
      else show_mismatch("inst_pc_o", got_pc, loop_start + 32'h20);
    assert (req_count == snap + 32'd4)
      else show_mismatch("request count", req_count, snap + 32'd4);

    // redirect held across a refill.
    wait_request();
    pulse_redirect(loop_start);
    wait_fetch_of(loop_start);

    repeat (4) @(posedge clock);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_mem_model.sv
`default_nettype none
`timescale 1ns/1ps

module tb_mem_model #(
  parameter logic [31:0] data_key  = 32'h0,
  parameter logic [31:0] lfsr_seed = 32'h1
) (
  input  logic        clock_i,
  input  logic        reset_i,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic [31:0] req_count_o
);

  // taps for x^32 + x^22 + x^2 + x + 1.
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;

  logic [31:0] lfsr_q;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ lfsr_taps;
    end
    return n;
  endfunction

  // one lfsr step per bit taken.
  task automatic take_bit(output logic b);
    b = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
  endtask

  // code lives from reset_pc to reset_pc+64, but any address answers.
  initial begin : respond
    logic [31:0] addr;
    logic        b;
    int unsigned lat;
    rvalid_o    = 1'b0;
    rdata_o     = '0;
    req_count_o = '0;
    lfsr_q      = lfsr_seed;
    forever begin
      @(posedge clock_i);
      #1;
      rvalid_o = 1'b0;
      if (!reset_i && arvalid_i) begin
        addr        = araddr_i;
        req_count_o = req_count_o + 32'd1;
        lat = 1; // 1 to 4 cycles.
        take_bit(b);
        if (b) begin
          lat = lat + 1;
        end
        take_bit(b);
        if (b) begin
          lat = lat + 2;
        end
        repeat (lat) @(posedge clock_i);
        #1;
        rvalid_o = 1'b1;
        rdata_o  = addr ^ data_key;
      end
    end
  end

endmodule

`default_nettype wire
